/* hw/dsc_pkg.sv */
//####################
// descriptor layout, read request and response,
// channel config and engine output types
//####################

package dsc_pkg;

    // marks a descriptor that may go to the engine
    localparam logic [15:0] dsc_magic = 16'had4b;

    // byte stride between descriptors in memory
    localparam int dsc_bytes = 32;

    typedef enum logic [0:0] {
        ch0 = 1'b0,
        ch1 = 1'b1
    } ch_e;

    typedef logic [29:0] seq_id_t;

    // adjacent is the size of the next block minus one
    typedef struct packed {
        logic [63:0]  next_addr;
        logic [159:0] payload;
        logic [8:0]   reserved;
        logic [5:0]   adjacent;
        logic [15:0]  magic;
        logic         stop;
    } dsc_t;

    typedef struct packed {
        logic [63:0] init_addr;
        logic [5:0]  init_size;
    } ch_cfg_t;

    typedef struct packed {
        logic [63:0] addr;
        logic [6:0]  count;
        ch_e         ch;
    } rd_req_t;

    typedef struct packed {
        dsc_t data;
        ch_e  ch;
        logic last;
    } rd_rsp_t;

    typedef struct packed {
        ch_e     ch;
        seq_id_t seq_id;
        dsc_t    dsc;
    } eng_dsc_t;

endpackage

/* hw/dsc_fifo.sv */
//####################
// descriptor FIFO with synchronous clear
//####################
`timescale 1ns/1ps

module dsc_fifo #(
    parameter int fifo_depth = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clear,
    input  logic                        push,
    input  dsc_pkg::dsc_t               din,
    input  logic                        pop,
    output dsc_pkg::dsc_t               dout,
    output logic                        empty,
    output logic [$clog2(fifo_depth):0] count
);
    import dsc_pkg::*;

    localparam int ptr_w = $clog2(fifo_depth);
    localparam logic [ptr_w:0] full_cnt = fifo_depth[ptr_w:0];

    dsc_t             mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // overflow and underflow are dropped
    assign do_push = push & (count != full_cnt);
    assign do_pop  = pop & !empty;

    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (!do_push && do_pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* hw/dsc_channel.sv */
//####################
// one channel: chain walker, block request,
// sequence id and descriptor queue
//####################
`timescale 1ns/1ps

module dsc_channel #(
    parameter int           fifo_depth = 16,
    parameter dsc_pkg::ch_e ch_idx     = dsc_pkg::ch0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  dsc_pkg::ch_cfg_t cfg,
    output logic             req,
    output dsc_pkg::rd_req_t req_info,
    input  logic             grant,
    input  logic             rsp_valid,
    input  dsc_pkg::dsc_t    rsp_data,
    input  logic             rsp_last,
    output logic             head_ok,
    output dsc_pkg::dsc_t    head,
    output dsc_pkg::seq_id_t seq_id,
    input  logic             pop
);
    import dsc_pkg::*;

    localparam int cnt_w = $clog2(fifo_depth) + 1;

    logic             start_r;
    logic             start_edge;
    logic             in_read;
    logic             done;
    logic [63:0]      next_addr;
    logic [5:0]       size;
    logic             has_room;
    logic             bad_head;
    logic             fifo_pop;
    logic             fifo_empty;
    logic [cnt_w-1:0] fifo_count;

    assign start_edge = start & !start_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_r <= 1'b0;
        end else begin
            start_r <= start;
        end
    end

    // block of size+1 descriptors must fit completely
    assign has_room = (fifo_depth - int'(fifo_count)) > int'(size);
    assign req      = start_r & !in_read & !done & has_room;

    always_comb begin
        req_info.addr  = next_addr;
        req_info.count = {1'b0, size} + 7'd1;
        req_info.ch    = ch_idx;
    end

    // one read open at a time, closed by its last beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_read <= 1'b0;
        end else if (grant) begin
            in_read <= 1'b1;
        end else if (rsp_valid && rsp_last) begin
            in_read <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_addr <= '0;
            size      <= '0;
        end else if (start_edge) begin
            next_addr <= cfg.init_addr;
            size      <= cfg.init_size;
        end else if (rsp_valid && rsp_last) begin
            next_addr <= rsp_data.next_addr;
            size      <= rsp_data.adjacent;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (start_edge) begin
            done <= 1'b0;
        end else if (rsp_valid && rsp_data.stop) begin
            done <= 1'b1;
        end
    end

    // counts only descriptors taken by the dispatcher
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seq_id <= '0;
        end else if (start_edge) begin
            seq_id <= '0;
        end else if (pop) begin
            seq_id <= seq_id + 1'b1;
        end
    end

    assign bad_head = !fifo_empty & (head.magic != dsc_magic);
    assign head_ok  = !fifo_empty & (head.magic == dsc_magic);
    assign fifo_pop = bad_head | pop;

    dsc_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (start_edge),
        .push  (rsp_valid),
        .din   (rsp_data),
        .pop   (fifo_pop),
        .dout  (head),
        .empty (fifo_empty),
        .count (fifo_count)
    );

endmodule

/* hw/dsc_read_arbiter.sv */
//####################
// shared read port owner and response router
//####################
`timescale 1ns/1ps

module dsc_read_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [1:0]             ch_req,
    input  dsc_pkg::rd_req_t [1:0] ch_info,
    output logic [1:0]             grant,
    output logic                   rd_valid,
    input  logic                   rd_ready,
    output dsc_pkg::rd_req_t       rd_req,
    input  logic                   rsp_valid,
    input  dsc_pkg::rd_rsp_t       rsp,
    output logic [1:0]             rsp_valid_ch
);
    import dsc_pkg::*;

    logic accept;
    logic load;

    assign accept = rd_valid & rd_ready;

    // new winner only while the port is idle
    assign load = !rd_valid & (|ch_req);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else if (accept) begin
            rd_valid <= 1'b0;
        end else if (load) begin
            rd_valid <= 1'b1;
        end
    end

    // channel 0 wins when both ask
    always_ff @(posedge clk) begin
        if (load) begin
            if (ch_req[0]) begin
                rd_req <= ch_info[0];
            end else begin
                rd_req <= ch_info[1];
            end
        end
    end

    assign grant[0] = accept & (rd_req.ch == ch0);
    assign grant[1] = accept & (rd_req.ch == ch1);

    // beats carry the channel they were requested for
    assign rsp_valid_ch[0] = rsp_valid & (rsp.ch == ch0);
    assign rsp_valid_ch[1] = rsp_valid & (rsp.ch == ch1);

endmodule

/* hw/dsc_dispatcher.sv */
//####################
// round-robin head selection onto the engine port
//####################
`timescale 1ns/1ps

module dsc_dispatcher (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [1:0]             head_ok,
    input  dsc_pkg::dsc_t [1:0]    head,
    input  dsc_pkg::seq_id_t [1:0] seq_id,
    output logic [1:0]             pop,
    input  logic                   eng_full,
    output logic                   eng_write,
    output dsc_pkg::eng_dsc_t      eng_dsc,
    output logic [1:0]             chan_done
);
    import dsc_pkg::*;

    ch_e rr_ptr;

    // pointer moves whether or not the pointed head is ready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= ch0;
        end else if (!eng_full) begin
            rr_ptr <= (rr_ptr == ch0) ? ch1 : ch0;
        end
    end

    assign eng_write = head_ok[rr_ptr] & !eng_full;

    always_comb begin
        eng_dsc.ch     = rr_ptr;
        eng_dsc.seq_id = seq_id[rr_ptr];
        eng_dsc.dsc    = head[rr_ptr];
    end

    assign pop[0] = eng_write & (rr_ptr == ch0);
    assign pop[1] = eng_write & (rr_ptr == ch1);

    // done leaves together with the stop descriptor
    assign chan_done[0] = pop[0] & head[0].stop;
    assign chan_done[1] = pop[1] & head[1].stop;

endmodule

/* hw/dsc_manager.sv */
//####################
// descriptor fetch manager top
// two channels, read arbiter, dispatcher
//####################
`timescale 1ns/1ps

module dsc_manager #(
    parameter int fifo_depth = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [1:0]             start,
    input  dsc_pkg::ch_cfg_t [1:0] cfg,
    output logic                   rd_valid,
    input  logic                   rd_ready,
    output dsc_pkg::rd_req_t       rd_req,
    input  logic                   rsp_valid,
    input  dsc_pkg::rd_rsp_t       rsp,
    input  logic                   eng_full,
    output logic                   eng_write,
    output dsc_pkg::eng_dsc_t      eng_dsc,
    output logic [1:0]             chan_done
);
    import dsc_pkg::*;

    logic [1:0]      ch_req;
    rd_req_t [1:0]   ch_info;
    logic [1:0]      grant;
    logic [1:0]      rsp_valid_ch;
    logic [1:0]      head_ok;
    dsc_t [1:0]      head;
    seq_id_t [1:0]   seq_id;
    logic [1:0]      pop;

    dsc_channel #(
        .fifo_depth (fifo_depth),
        .ch_idx     (ch0)
    ) u_ch0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start[0]),
        .cfg       (cfg[0]),
        .req       (ch_req[0]),
        .req_info  (ch_info[0]),
        .grant     (grant[0]),
        .rsp_valid (rsp_valid_ch[0]),
        .rsp_data  (rsp.data),
        .rsp_last  (rsp.last),
        .head_ok   (head_ok[0]),
        .head      (head[0]),
        .seq_id    (seq_id[0]),
        .pop       (pop[0])
    );

    dsc_channel #(
        .fifo_depth (fifo_depth),
        .ch_idx     (ch1)
    ) u_ch1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start[1]),
        .cfg       (cfg[1]),
        .req       (ch_req[1]),
        .req_info  (ch_info[1]),
        .grant     (grant[1]),
        .rsp_valid (rsp_valid_ch[1]),
        .rsp_data  (rsp.data),
        .rsp_last  (rsp.last),
        .head_ok   (head_ok[1]),
        .head      (head[1]),
        .seq_id    (seq_id[1]),
        .pop       (pop[1])
    );

    dsc_read_arbiter u_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .ch_req       (ch_req),
        .ch_info      (ch_info),
        .grant        (grant),
        .rd_valid     (rd_valid),
        .rd_ready     (rd_ready),
        .rd_req       (rd_req),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .rsp_valid_ch (rsp_valid_ch)
    );

    dsc_dispatcher u_disp (
        .clk       (clk),
        .rst_n     (rst_n),
        .head_ok   (head_ok),
        .head      (head),
        .seq_id    (seq_id),
        .pop       (pop),
        .eng_full  (eng_full),
        .eng_write (eng_write),
        .eng_dsc   (eng_dsc),
        .chan_done (chan_done)
    );

endmodule

/* testbench/dsc_manager_checker.sv */
//####################
// concurrent assertions on the manager ports
//####################
`timescale 1ns/1ps

module dsc_manager_checker (
    input logic             clk,
    input logic             rst_n,
    input logic             rd_valid,
    input logic             rd_ready,
    input dsc_pkg::rd_req_t rd_req,
    input logic             eng_full,
    input logic             eng_write,
    input logic [1:0]       chan_done
);

    no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) eng_full |-> !eng_write
    ) else $error("engine write while engine full");

    // request held until the memory takes it
    req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rd_valid && !rd_ready) |=> (rd_valid && $stable(rd_req))
    ) else $error("read request changed while waiting for ready");

    done_with_write: assert property (
        @(posedge clk) disable iff (!rst_n) (|chan_done) |-> eng_write
    ) else $error("channel done without engine write");

endmodule

bind dsc_manager dsc_manager_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .rd_req    (rd_req),
    .eng_full  (eng_full),
    .eng_write (eng_write),
    .chan_done (chan_done)
);

/* testbench/tb_dsc_manager.sv */
//####################
// testbench for the descriptor fetch manager
// memory model, chain builder, reference walk,
// stimulus and stream comparison
//####################
`timescale 1ns/1ps

module tb_dsc_manager;
    import dsc_pkg::*;

    logic               clk;
    logic               rst_n;
    logic [1:0]         start;
    ch_cfg_t [1:0]      cfg;
    logic               rd_valid;
    logic               rd_ready;
    rd_req_t            rd_req;
    logic               rsp_valid;
    rd_rsp_t            rsp;
    logic               eng_full;
    logic               eng_write;
    eng_dsc_t           eng_dsc;
    logic [1:0]         chan_done;

    dsc_t               mem [logic [63:0]];
    logic [31:0]        lfsr;
    string              test_name;
    bit                 bp_on = 1'b0;
    eng_dsc_t           exp_q0[$];
    eng_dsc_t           exp_q1[$];
    int                 stop0 = -1;
    int                 stop1 = -1;
    int                 req_cnt [2];
    rd_req_t            req_q[$];
    rd_req_t            cur_req;
    int                 beats_left = 0;
    int                 beat_idx = 0;
    int                 delay_cnt = 0;
    bit                 hold_req = 1'b0;
    rd_req_t            held_req;
    ch_cfg_t            cfg_a;
    ch_cfg_t            cfg_b;
    ch_cfg_t            cfg_c;
    ch_cfg_t            cfg_d;
    ch_cfg_t            cfg_e;

    dsc_manager #(
        .fifo_depth (16)
    ) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cfg       (cfg),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_req    (rd_req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .eng_full  (eng_full),
        .eng_write (eng_write),
        .eng_dsc   (eng_dsc),
        .chan_done (chan_done)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // fibonacci lfsr on taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_eng(input eng_dsc_t exp, input eng_dsc_t act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected %h, actual %h", test_name, exp, act);
            abort_run("engine descriptor differs from the reference");
        end
    endtask

    task automatic verify_done(input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected %b, actual %b", test_name, exp, act);
            abort_run("channel done flags differ from the reference");
        end
    endtask

    task automatic expect_level(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch in %s: %s expected %b, actual %b", test_name, what, exp, act);
            abort_run("output level differs from the reference");
        end
    endtask

    task automatic match_count(input int exp, input int act);
        if (act != exp) begin
            $display("Mismatch in %s: expected %0d, actual %0d", test_name, exp, act);
            abort_run("number of block reads differs from the reference");
        end
    endtask

    // blocks sit in 4 KiB slots and the last one ends in a stop
    task automatic build_chain(input logic [63:0] base, input int nblocks, output ch_cfg_t c);
        logic [63:0] addr;
        logic [63:0] nxt_addr;
        logic [5:0]  sz;
        logic [5:0]  nxt_sz;
        dsc_t        d;
        addr = base + 64'(rand_bits(6) * dsc_bytes);
        sz = 6'(rand_bits(3));
        c.init_addr = addr;
        c.init_size = sz;
        for (int b = 0; b < nblocks; b++) begin
            nxt_addr = base + 64'((b + 1) * 'h1000) + 64'(rand_bits(6) * dsc_bytes);
            nxt_sz = 6'(rand_bits(3));
            if (nxt_sz == sz) begin
                nxt_sz = 6'((sz + 1) % 8);
            end
            for (int i = 0; i <= int'(sz); i++) begin
                d.next_addr = {rand_bits(32), rand_bits(32)};
                d.payload = {rand_bits(32), rand_bits(32), rand_bits(32),
                             rand_bits(32), rand_bits(32)};
                d.reserved = '0;
                d.adjacent = 6'(rand_bits(6));
                d.magic = (rand_bits(3) == 0) ? ~dsc_magic : dsc_magic;
                d.stop = 1'b0;
                if (i == int'(sz)) begin
                    d.next_addr = nxt_addr;
                    d.adjacent = nxt_sz;
                    if (b == nblocks - 1) begin
                        d.stop = 1'b1;
                        d.magic = dsc_magic;
                    end
                end
                mem[addr + 64'(i * dsc_bytes)] = d;
            end
            addr = nxt_addr;
            sz = nxt_sz;
        end
    endtask

    // expected stream of one channel and the seq_id of its stop descriptor
    function automatic int walk_chain(input ch_e ch, input ch_cfg_t c,
                                      output eng_dsc_t list[$], output int blocks);
        logic [63:0] addr;
        logic [63:0] nxt_addr;
        int          n;
        int          nxt_n;
        int          seq;
        int          stop_idx;
        bit          found;
        dsc_t        d;
        eng_dsc_t    e;
        list = {};
        blocks = 0;
        addr = c.init_addr;
        n = int'(c.init_size);
        seq = 0;
        stop_idx = -1;
        found = 1'b0;
        nxt_addr = '0;
        nxt_n = 0;
        while (!found && blocks < 64) begin
            blocks++;
            for (int i = 0; i <= n; i++) begin
                d = mem[addr + 64'(i * dsc_bytes)];
                if (d.magic == dsc_magic) begin
                    e.ch = ch;
                    e.seq_id = seq_id_t'(seq);
                    e.dsc = d;
                    list.push_back(e);
                    if (d.stop && stop_idx < 0) begin
                        stop_idx = seq;
                    end
                    seq++;
                end
                // rest of the block still arrives after a stop
                if (d.stop) begin
                    found = 1'b1;
                end
                if (i == n) begin
                    nxt_addr = d.next_addr;
                    nxt_n = int'(d.adjacent);
                end
            end
            addr = nxt_addr;
            n = nxt_n;
        end
        return stop_idx;
    endfunction

    // memory model and random back-pressure
    always @(posedge clk) begin : mem_model
        rd_rsp_t r;
        if (rst_n) begin
            if (bp_on) begin
                rd_ready <= (rand_bits(2) != 0);
                eng_full <= (rand_bits(2) == 0);
            end else begin
                rd_ready <= 1'b1;
                eng_full <= 1'b0;
            end
            rsp_valid <= 1'b0;
            if (beats_left == 0 && req_q.size() != 0) begin
                if (delay_cnt == 0) begin
                    cur_req = req_q.pop_front();
                    beats_left = int'(cur_req.count);
                    beat_idx = 0;
                    delay_cnt = int'(rand_bits(3));
                end else begin
                    delay_cnt--;
                end
            end
            if (beats_left != 0) begin
                r.data = mem[cur_req.addr + 64'(beat_idx * dsc_bytes)];
                r.ch = cur_req.ch;
                r.last = (beats_left == 1);
                rsp <= r;
                rsp_valid <= 1'b1;
                beat_idx++;
                beats_left--;
            end
        end
    end

    // request capture and stream comparison
    always @(negedge clk) begin : monitor
        eng_dsc_t   exp;
        logic [1:0] exp_done;
        if (rst_n) begin
            if (eng_write && eng_full) begin
                abort_run("engine write while the engine is full");
            end
            if (hold_req && (!rd_valid || rd_req != held_req)) begin
                abort_run("read request changed before it was accepted");
            end
            hold_req = rd_valid && !rd_ready;
            held_req = rd_req;
            if (rd_valid && rd_ready) begin
                if (!mem.exists(rd_req.addr)) begin
                    abort_run("read request to an address with no descriptor");
                end
                req_q.push_back(rd_req);
                req_cnt[rd_req.ch]++;
            end
            if (eng_write) begin
                exp_done = 2'b00;
                if (eng_dsc.ch == ch0 && exp_q0.size() == 0) begin
                    abort_run("descriptor on channel 0 with none expected");
                end else if (eng_dsc.ch == ch1 && exp_q1.size() == 0) begin
                    abort_run("descriptor on channel 1 with none expected");
                end else if (eng_dsc.ch == ch0) begin
                    exp = exp_q0.pop_front();
                    exp_done[0] = (int'(exp.seq_id) == stop0);
                end else begin
                    exp = exp_q1.pop_front();
                    exp_done[1] = (int'(exp.seq_id) == stop1);
                end
                compare_eng(exp, eng_dsc);
                verify_done(exp_done, chan_done);
            end else begin
                verify_done(2'b00, chan_done);
            end
        end
    end

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (exp_q0.size() != 0 || exp_q1.size() != 0 || req_q.size() != 0
               || beats_left != 0 || rd_valid) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                abort_run("timeout waiting for the descriptor streams to finish");
            end
        end
    endtask

    // rising start edge on the chosen channels and a run to completion
    task automatic launch(input logic [1:0] which, input ch_cfg_t c0, input ch_cfg_t c1);
        eng_dsc_t list[$];
        int       blocks0;
        int       blocks1;
        blocks0 = 0;
        blocks1 = 0;
        @(posedge clk);
        req_cnt[0] = 0;
        req_cnt[1] = 0;
        if (which[0]) begin
            stop0 = walk_chain(ch0, c0, list, blocks0);
            exp_q0 = list;
        end
        if (which[1]) begin
            stop1 = walk_chain(ch1, c1, list, blocks1);
            exp_q1 = list;
        end
        start <= start & ~which;
        @(posedge clk);
        start <= start | which;
        if (which[0]) begin
            cfg[0] <= c0;
        end
        if (which[1]) begin
            cfg[1] <= c1;
        end
        wait_idle(5000);
        // window in which a finished channel must stay quiet
        repeat (20) @(negedge clk);
        match_count(blocks0, req_cnt[0]);
        match_count(blocks1, req_cnt[1]);
    endtask

    initial begin
        lfsr = 32'hae7d;
        rst_n = 1'b0;
        start = '0;
        cfg = '0;
        rd_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp = '0;
        eng_full = 1'b0;
        test_name = "build";
        build_chain(64'h0010_0000, 4, cfg_a);
        build_chain(64'h0020_0000, 3, cfg_b);
        build_chain(64'h0030_0000, 5, cfg_c);
        build_chain(64'h0040_0000, 4, cfg_d);
        build_chain(64'h0050_0000, 3, cfg_e);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "reset";
        repeat (10) begin
            @(negedge clk);
            expect_level("rd_valid", 1'b0, rd_valid);
            expect_level("eng_write", 1'b0, eng_write);
            verify_done(2'b00, chan_done);
        end

        test_name = "single_ch0";
        launch(2'b01, cfg_a, '0);

        test_name = "both_channels";
        launch(2'b11, cfg_b, cfg_c);

        test_name = "back_pressure";
        bp_on = 1'b1;
        launch(2'b11, cfg_d, cfg_e);

        test_name = "restart_ch1";
        launch(2'b10, '0, cfg_a);

        $display("TEST PASS");
        $finish;
    end

endmodule

/* all.f */
hw/dsc_pkg.sv
hw/dsc_fifo.sv
hw/dsc_channel.sv
hw/dsc_read_arbiter.sv
hw/dsc_dispatcher.sv
hw/dsc_manager.sv
testbench/dsc_manager_checker.sv
testbench/tb_dsc_manager.sv

/* Bender.yml */
package:
  name: dsc_manager

sources:
  - hw/dsc_pkg.sv
  - hw/dsc_fifo.sv
  - hw/dsc_channel.sv
  - hw/dsc_read_arbiter.sv
  - hw/dsc_dispatcher.sv
  - hw/dsc_manager.sv
  - target: test
    files:
      - testbench/dsc_manager_checker.sv
      - testbench/tb_dsc_manager.sv
